// File: design/bk_mem_pkg.sv
// shared widths and slot map for the bk memory side; slot positions assume a 16 pixel cycle
`default_nettype none

package bk_mem_pkg;

    // ==================================================
    // vector types
    // ==================================================
    typedef logic [15:0] word_t;       // cpu, host and sram data
    typedef logic [15:0] byte_addr_t;  // cpu byte address
    typedef logic [15:0] ram_addr_t;   // sram word address
    typedef logic [12:0] vid_addr_t;   // 8 line bits over 5 column bits
    typedef logic [7:0]  roll_t;       // vertical scroll register
    typedef logic [9:0]  pix_t;        // screen x or y count
    typedef logic [3:0]  slot_t;       // position in the 16 pixel cycle

    // ==================================================
    // slot map
    // ==================================================
    localparam slot_t SLOT_VIDEO = 4'd0;  // screen word read
    localparam slot_t SLOT_CPU0  = 4'd4;  // first cpu enable
    localparam slot_t SLOT_CPU1  = 4'd5;  // second cpu enable, strobe slot

    // screen buffer placement
    localparam logic [2:0] VIDEO_PAGE  = 3'b001;  // upper sram address bits
    localparam roll_t      SCREEN_BASE = 8'o330;  // line offset before the scroll

    // debug host register map
    // the breakpoint register sits above the sram window the host normally uses
    localparam ram_addr_t BP_REG_ADDR = 16'h8000;

endpackage : bk_mem_pkg

`default_nettype wire

// File: design/cpu_bus_sequencer.sv
// the cpu must hold cpu_rd or cpu_wt until slot 6 has passed and present a byte on its own lane
`timescale 1ns/10ps
`default_nettype none

module cpu_bus_sequencer
    import bk_mem_pkg::*;
(
    input  wire             clk25,
    input  wire             reset_in,
    input  wire             cpu_rd,         // read level from the cpu
    input  wire             cpu_wt,         // write level from the cpu
    input  wire             cpu_byte,
    input  wire             ifetch,
    input  wire byte_addr_t cpu_adr,
    input  wire word_t      cpu_wdata,
    input  wire word_t      ram_rdata,
    input  wire             cpu_ce,         // slots 4 and 5
    input  wire             cpu_pause,
    input  wire             bp_enable,
    input  wire             step,
    input  wire byte_addr_t bp_addr,
    output logic            cpu_oe,
    output logic            cpu_we,
    output logic            cpu_lb_n,
    output logic            cpu_ub_n,
    output logic            cpu_rdy,
    output ram_addr_t       cpu_word_addr,
    output word_t           cpu_rdata
);

    logic [2:0] seq;        // slot history, bit 0 is the newest
    logic       ce_q;       // cpu_ce of the previous cycle
    logic       step_q;     // step as seen in the last slot 4
    logic       bp_latch;   // cpu held at a breakpoint
    logic       slot4;
    logic       bp_hit;
    logic       step_rise;
    logic       seq_in;

    assign slot4     = cpu_ce & ~ce_q;  // first of the two enable cycles
    assign bp_hit    = bp_enable & ifetch & cpu_rd & (cpu_adr == bp_addr);
    assign step_rise = step & ~step_q;

    assign cpu_rdy = ~cpu_pause & ~bp_latch;

    // a held cpu starts nothing, but slot 5 still follows a slot 4 that started
    assign seq_in = (cpu_rd | cpu_wt) & cpu_ce & (cpu_rdy | seq[0]);

    // ==================================================
    // slot history and breakpoint latch
    // ==================================================
    always_ff @(posedge clk25) begin
        if (reset_in) begin
            seq      <= 3'b000;
            ce_q     <= 1'b0;
            step_q   <= 1'b0;
            bp_latch <= 1'b0;
        end else begin
            ce_q <= cpu_ce;
            seq  <= {seq[1:0], seq_in};
            if (slot4) begin
                step_q <= step;
                if (step_rise)
                    bp_latch <= 1'b0;  // step releases the cpu
                else if (bp_hit)
                    bp_latch <= 1'b1;
            end
        end
    end

    // 001 in slot 5, 011 in slot 6
    assign cpu_oe = cpu_rd & seq[0] & ~seq[2];
    assign cpu_we = cpu_wt & (seq[1:0] == 2'b01);  // slot 5 only

    // odd byte uses the upper lane, even byte the lower one
    assign cpu_lb_n = cpu_byte & cpu_adr[0];
    assign cpu_ub_n = cpu_byte & ~cpu_adr[0];

    assign cpu_word_addr = {1'b0, cpu_adr[15:1]};

    // read data sampled at the end of slot 5
    always_ff @(posedge clk25) begin
        if (cpu_oe && (seq == 3'b001))
            cpu_rdata <= ram_rdata;
    end

    // ==================================================
    // checks
    // ==================================================
    a_oe_we_excl: assert property (@(posedge clk25) disable iff (reset_in)
        !(cpu_oe && cpu_we));

    // write strobe only right behind the enable
    a_we_after_ce: assert property (@(posedge clk25) disable iff (reset_in)
        cpu_we |-> $past(cpu_ce));

    // write data is taken by the arbiter, the sequencer only watches it for x
    a_wdata_known: assert property (@(posedge clk25) disable iff (reset_in)
        cpu_we |-> !$isunknown(cpu_wdata));

endmodule : cpu_bus_sequencer

`default_nettype wire

// File: design/video_fetch.sv
// H_TOTAL must be a multiple of 16; vertical sync sits just below the V_ACTIVE line window
`timescale 1ns/10ps
`default_nettype none

module video_fetch
    import bk_mem_pkg::*;
#(
    parameter int H_TOTAL  = 800,
    parameter int V_TOTAL  = 525,
    parameter int V_ACTIVE = 512
) (
    input  wire        clk25,
    input  wire        reset_in,
    input  wire roll_t roll,           // scroll register of the cpu
    output logic       cpu_ce,
    output logic       vid_req,
    output logic       hs,             // active low
    output logic       vs,             // active low
    output logic       screen_valid,
    output vid_addr_t  vid_addr
);

    // 640x480 horizontal porches counted back from the line end
    localparam int HS_START = H_TOTAL - 144;
    localparam int HS_END   = H_TOTAL - 48;
    localparam int VS_START = V_ACTIVE + 3;  // short front porch
    localparam int VS_END   = V_ACTIVE + 5;  // 2 line pulse

    pix_t  x;
    pix_t  y;
    slot_t slot;
    roll_t line_ofs;
    logic  line_active;

    // ==================================================
    // pixel and line counters
    // ==================================================
    always_ff @(posedge clk25) begin
        if (reset_in) begin
            x <= '0;
            y <= '0;
        end else if (x == pix_t'(H_TOTAL - 1)) begin
            x <= '0;
            if (y == pix_t'(V_TOTAL - 1))
                y <= '0;
            else
                y <= y + 1'b1;
        end else begin
            x <= x + 1'b1;
        end
    end

    assign slot = x[3:0];

    assign hs = ~((x >= pix_t'(HS_START)) && (x < pix_t'(HS_END)));
    assign vs = ~((y >= pix_t'(VS_START)) && (y < pix_t'(VS_END)));

    assign line_active  = y < pix_t'(V_ACTIVE);
    assign screen_valid = line_active && (x < pix_t'(512));  // 512 pixel wide bk screen

    // ==================================================
    // slot decode and screen address
    // ==================================================
    assign cpu_ce  = (slot == SLOT_CPU0) || (slot == SLOT_CPU1);
    assign vid_req = (slot == SLOT_VIDEO) && line_active;

    // each bk line is shown twice, so y bit 0 drops out
    assign line_ofs = y[8:1] - SCREEN_BASE + roll;
    assign vid_addr = {line_ofs, x[8:4]};

    a_vid_cpu_apart: assert property (@(posedge clk25) disable iff (reset_in)
        !(vid_req && cpu_ce));

endmodule : video_fetch

`default_nettype wire

// File: design/sram_arbiter.sv
// purely combinational sram mux; the host gets full words only and the cpu wins any collision
`timescale 1ns/10ps
`default_nettype none

module sram_arbiter
    import bk_mem_pkg::*;
(
    input  wire            clk25,
    input  wire            reset_in,
    input  wire            cpu_oe,
    input  wire            cpu_we,
    input  wire            cpu_lb_n,
    input  wire            cpu_ub_n,
    input  wire ram_addr_t cpu_word_addr,
    input  wire word_t     cpu_wdata,
    input  wire            host_oe,
    input  wire            host_we,
    input  wire ram_addr_t host_addr,
    input  wire word_t     host_wdata,
    input  wire            vid_req,
    input  wire vid_addr_t vid_addr,
    input  wire word_t     ram_rdata,
    output ram_addr_t      ram_addr,
    output word_t          ram_wdata,
    output logic           ram_oe_n,
    output logic           ram_we_n,
    output logic           ram_lb_n,
    output logic           ram_ub_n,
    output logic           video_load,  // screen word on ram_rdata
    output word_t          host_rdata,
    output byte_addr_t     bp_addr
);

    logic cpu_act;
    logic host_act;
    logic host_reg;   // host addresses the breakpoint register
    logic host_ram;   // host owns the sram this cycle
    logic vid_sel;

    assign cpu_act  = cpu_oe | cpu_we;
    assign host_act = host_oe | host_we;
    assign host_reg = host_addr == BP_REG_ADDR;
    assign host_ram = host_act & ~cpu_act & ~host_reg;
    assign vid_sel  = vid_req & ~cpu_act & ~host_act;  // any host level steals the slot

    assign video_load = vid_sel;

    // ==================================================
    // sram mux, cpu then host then video
    // ==================================================
    always_comb begin
        if (cpu_act)
            ram_addr = cpu_word_addr;
        else if (host_act)
            ram_addr = host_addr;
        else
            ram_addr = {VIDEO_PAGE, vid_addr};
    end

    assign ram_wdata = cpu_we ? cpu_wdata : host_wdata;

    // host write beats host read when both levels are up
    assign ram_oe_n = ~(cpu_oe | (host_ram & host_oe & ~host_we) | vid_sel);
    assign ram_we_n = ~(cpu_we | (host_ram & host_we));  // video never writes

    // lanes idle high, host and video take the full word
    assign ram_lb_n = cpu_act ? cpu_lb_n : ~(host_ram | vid_sel);
    assign ram_ub_n = cpu_act ? cpu_ub_n : ~(host_ram | vid_sel);

    // ==================================================
    // breakpoint register
    // ==================================================
    always_ff @(posedge clk25) begin
        if (reset_in)
            bp_addr <= '0;
        else if (host_we && host_reg)
            bp_addr <= byte_addr_t'(host_wdata);  // off the sram, no wait for the cpu
    end

    assign host_rdata = host_reg ? word_t'(bp_addr) : ram_rdata;

    a_no_oe_with_we: assert property (@(posedge clk25) disable iff (reset_in)
        !ram_we_n |-> ram_oe_n);

endmodule : sram_arbiter

`default_nettype wire

// File: design/bk_memory_top.sv
// memory side only; the cpu core, pixel shifter and host transport live outside this top
`timescale 1ns/10ps
`default_nettype none

module bk_memory_top
    import bk_mem_pkg::*;
#(
    parameter int H_TOTAL  = 800,
    parameter int V_TOTAL  = 525,
    parameter int V_ACTIVE = 512
) (
    input  wire             clk25,
    input  wire             reset_in,
    // cpu side
    input  wire             cpu_rd,
    input  wire             cpu_wt,
    input  wire byte_addr_t cpu_adr,
    input  wire             cpu_byte,
    input  wire             ifetch,
    input  wire word_t      cpu_wdata,
    output wire word_t      cpu_rdata,
    output wire             cpu_rdy,
    output wire             cpu_ce,
    // debug host
    input  wire             host_oe,
    input  wire             host_we,
    input  wire ram_addr_t  host_addr,
    input  wire word_t      host_wdata,
    output wire word_t      host_rdata,
    // switches
    input  wire             cpu_pause,
    input  wire             bp_enable,
    input  wire             step,
    input  wire roll_t      roll,
    // sram pins
    output wire ram_addr_t  ram_addr,
    output wire word_t      ram_wdata,
    input  wire word_t      ram_rdata,
    output wire             ram_oe_n,
    output wire             ram_we_n,
    output wire             ram_lb_n,
    output wire             ram_ub_n,
    // video timing
    output wire             hs,
    output wire             vs,
    output wire             video_load
);

    wire             cpu_oe;
    wire             cpu_we;
    wire             cpu_lb_n;
    wire             cpu_ub_n;
    wire ram_addr_t  cpu_word_addr;
    wire             vid_req;
    wire vid_addr_t  vid_addr;
    wire byte_addr_t bp_addr;  // arbiter register back to the sequencer

    cpu_bus_sequencer seq0 (
        .clk25(clk25), .reset_in(reset_in),
        .cpu_rd(cpu_rd), .cpu_wt(cpu_wt), .cpu_byte(cpu_byte), .ifetch(ifetch),
        .cpu_adr(cpu_adr), .cpu_wdata(cpu_wdata), .ram_rdata(ram_rdata),
        .cpu_ce(cpu_ce), .cpu_pause(cpu_pause), .bp_enable(bp_enable), .step(step),
        .bp_addr(bp_addr), .cpu_oe(cpu_oe), .cpu_we(cpu_we),
        .cpu_lb_n(cpu_lb_n), .cpu_ub_n(cpu_ub_n), .cpu_rdy(cpu_rdy),
        .cpu_word_addr(cpu_word_addr), .cpu_rdata(cpu_rdata)
    );

    video_fetch #(
        .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL), .V_ACTIVE(V_ACTIVE)
    ) vid0 (
        .clk25(clk25), .reset_in(reset_in), .roll(roll),
        .cpu_ce(cpu_ce), .vid_req(vid_req), .hs(hs), .vs(vs),
        .screen_valid(),  // feeds the pixel shifter, not part of this design
        .vid_addr(vid_addr)
    );

    sram_arbiter arb0 (
        .clk25(clk25), .reset_in(reset_in),
        .cpu_oe(cpu_oe), .cpu_we(cpu_we), .cpu_lb_n(cpu_lb_n), .cpu_ub_n(cpu_ub_n),
        .cpu_word_addr(cpu_word_addr), .cpu_wdata(cpu_wdata),
        .host_oe(host_oe), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .vid_req(vid_req), .vid_addr(vid_addr),
        .ram_rdata(ram_rdata), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
        .ram_oe_n(ram_oe_n), .ram_we_n(ram_we_n), .ram_lb_n(ram_lb_n),
        .ram_ub_n(ram_ub_n), .video_load(video_load), .host_rdata(host_rdata),
        .bp_addr(bp_addr)
    );

endmodule : bk_memory_top

`default_nettype wire

// File: testbench/tb_bk_memory.sv
// run from the project root so the pattern file is found; covers a few screen lines, no full frame
`timescale 1ns/10ps
`default_nettype none

module tb_bk_memory;

    localparam int H_TOTAL  = 800;
    localparam int V_TOTAL  = 525;
    localparam int V_ACTIVE = 512;
    localparam logic [7:0] SCR_BASE = 8'o330;  // line offset before the scroll

    logic        clk25 = 1'b0;
    logic        reset_in;
    logic        cpu_rd, cpu_wt, cpu_byte, ifetch;
    logic [15:0] cpu_adr, cpu_wdata, cpu_rdata;
    logic        cpu_rdy, cpu_ce;
    logic        host_oe, host_we;
    logic [15:0] host_addr, host_wdata, host_rdata;
    logic        cpu_pause, bp_enable, step;
    logic [7:0]  roll;
    logic [15:0] ram_addr, ram_wdata, ram_rdata;
    logic        ram_oe_n, ram_we_n, ram_lb_n, ram_ub_n;
    logic        hs, vs, video_load;

    logic [15:0] mem [0:65535];   // sram model
    logic [15:0] pat [0:255];     // op, addr, data, expect per row
    int          checks = 0;
    int          errors = 0;
    int          vid_loads = 0;
    logic [9:0]  tx, ty;          // tracked pixel and line
    logic        hs_q, vs_q, prev_ce;
    logic [7:0]  line_ofs;
    logic        exp_load;

    always #20 clk25 = ~clk25;    // 25 MHz

    bk_memory_top #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL), .V_ACTIVE(V_ACTIVE)) dut0 (
        .clk25(clk25), .reset_in(reset_in),
        .cpu_rd(cpu_rd), .cpu_wt(cpu_wt), .cpu_adr(cpu_adr), .cpu_byte(cpu_byte),
        .ifetch(ifetch), .cpu_wdata(cpu_wdata), .cpu_rdata(cpu_rdata),
        .cpu_rdy(cpu_rdy), .cpu_ce(cpu_ce),
        .host_oe(host_oe), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_rdata(host_rdata),
        .cpu_pause(cpu_pause), .bp_enable(bp_enable), .step(step), .roll(roll),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_rdata(ram_rdata),
        .ram_oe_n(ram_oe_n), .ram_we_n(ram_we_n), .ram_lb_n(ram_lb_n),
        .ram_ub_n(ram_ub_n), .hs(hs), .vs(vs), .video_load(video_load)
    );

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // ==================================================
    // sram model and strobe timing
    // ==================================================
    assign ram_rdata = ram_oe_n ? 16'hxxxx : mem[ram_addr];  // async read, floats without oe

    always @(negedge clk25) begin
        if (!ram_we_n) begin
            if (!ram_lb_n)
                mem[ram_addr][7:0] <= ram_wdata[7:0];
            if (!ram_ub_n)
                mem[ram_addr][15:8] <= ram_wdata[15:8];
            if (!host_we) begin          // cpu write, slot 5 only
                checks++;
                assert (prev_ce && cpu_ce)
                else begin
                    errors++;
                    $display("cpu write strobe came outside the cycle after cpu_ce");
                end
            end
        end
        prev_ce <= cpu_ce;
    end

    // ==================================================
    // screen position tracker and video address check
    // ==================================================
    always @(negedge clk25) begin
        if (reset_in) begin
            tx = '0;
            ty = '0;
            hs_q = 1'b1;
            vs_q = 1'b1;
        end else begin
            if (hs && !hs_q)
                check_value("tracked x at hs rise", 16'(tx), 16'(H_TOTAL - 48));
            if (vs && !vs_q)
                check_value("tracked y at vs rise", 16'(ty), 16'(V_ACTIVE + 5));
            exp_load = (tx[3:0] == 4'd0) && (ty < V_ACTIVE) && !host_oe && !host_we;
            check_value("video_load", 16'(video_load), 16'(exp_load));
            if (video_load) begin
                vid_loads++;
                line_ofs = ty[8:1] - SCR_BASE + roll;  // line pairs, then scroll
                check_value("ram_addr", ram_addr, {3'b001, line_ofs, tx[8:4]});
                check_value("ram_oe_n", 16'(ram_oe_n), 16'h0);
            end
            if (tx == 10'(H_TOTAL - 1)) begin
                tx = '0;
                ty = (ty == 10'(V_TOTAL - 1)) ? 10'd0 : ty + 1'b1;
            end else begin
                tx = tx + 1'b1;
            end
            hs_q = hs;
            vs_q = vs;
        end
    end

    // ==================================================
    // cpu side helpers
    // ==================================================
    task automatic wait_ce_low();
        int   n;
        logic done;
        done = 1'b0;
        for (n = 0; n < 40 && !done; n++) begin
            @(negedge clk25);
            done = !cpu_ce;
        end
        assert (done) else begin
            errors++;
            $display("timeout while waiting for cpu_ce to go low");
        end
    endtask

    // returns mid slot 6, read data valid there
    task automatic wait_ce_fall(input string what);
        int   n;
        logic seen;
        logic done;
        seen = 1'b0;
        done = 1'b0;
        for (n = 0; n < 40 && !done; n++) begin
            @(negedge clk25);
            if (cpu_ce)
                seen = 1'b1;
            else if (seen)
                done = 1'b1;
        end
        assert (done) else begin
            errors++;
            $display("timeout while waiting for the end of the %s", what);
        end
    endtask

    task automatic cpu_start(input logic wr, input logic bsel, input logic fetch,
                             input logic [15:0] adr, input logic [15:0] data);
        wait_ce_low();                  // never start inside slots 4 and 5
        @(posedge clk25);
        cpu_adr   <= adr;
        cpu_wdata <= data;
        cpu_byte  <= bsel;
        ifetch    <= fetch;
        bp_enable <= fetch;
        cpu_rd    <= !wr;
        cpu_wt    <= wr;
    endtask

    task automatic cpu_release();
        @(posedge clk25);
        cpu_rd   <= 1'b0;
        cpu_wt   <= 1'b0;
        cpu_byte <= 1'b0;
        ifetch   <= 1'b0;
    endtask

    // ==================================================
    // pattern driven stimulus
    // ==================================================
    initial begin
        logic [15:0] op, adr, dat, exp;
        int i;
        reset_in = 1'b1;
        {cpu_rd, cpu_wt, cpu_byte, ifetch} = 4'b0;
        cpu_adr = '0;
        cpu_wdata = '0;
        {host_oe, host_we, cpu_pause, bp_enable, step} = 5'b0;
        host_addr = '0;
        host_wdata = '0;
        roll = '0;
        for (i = 0; i < 65536; i++)
            mem[i] = 16'(i) ^ 16'ha5c3;  // fill tied to the whole address
        for (i = 0; i < 256; i++)
            pat[i] = 16'hffff;
        $readmemh("testbench/bk_memory_patterns.txt", pat);
        repeat (4) @(posedge clk25);
        reset_in <= 1'b0;

        for (i = 0; i < 64 && pat[4*i] != 16'hffff; i++) begin
            op  = pat[4*i];
            adr = pat[4*i+1];
            dat = pat[4*i+2];
            exp = pat[4*i+3];
            case (op)
                16'h0, 16'h1, 16'h2: begin      // cpu read, word write, byte write
                    cpu_start(op != 16'h0, op == 16'h2, 1'b0, adr, dat);
                    wait_ce_fall("cpu access");
                    if (op == 16'h0)
                        check_value("cpu_rdata", cpu_rdata, exp);
                    cpu_release();
                    if (op != 16'h0)
                        check_value("sram word", mem[{1'b0, adr[15:1]}], exp);
                end
                16'h3: begin                    // host write, one cycle
                    @(posedge clk25);
                    host_addr  <= adr;
                    host_wdata <= dat;
                    host_we    <= 1'b1;
                    @(posedge clk25);
                    host_we <= 1'b0;
                    check_value("sram word", mem[adr], exp);
                end
                16'h4: begin                    // host read
                    @(posedge clk25);
                    host_addr <= adr;
                    host_oe   <= 1'b1;
                    @(negedge clk25);
                    check_value("host_rdata", host_rdata, exp);
                    @(posedge clk25);
                    host_oe <= 1'b0;
                end
                16'h5: begin                    // fetch at the breakpoint
                    cpu_start(1'b0, 1'b0, 1'b1, adr, dat);
                    wait_ce_fall("breakpoint fetch");
                    check_value("cpu_rdata", cpu_rdata, exp);
                    check_value("cpu_rdy", 16'(cpu_rdy), 16'h0);
                    cpu_release();
                    wait_ce_fall("held period");
                    check_value("cpu_rdy", 16'(cpu_rdy), 16'h0);
                    @(posedge clk25);
                    step <= 1'b1;
                    wait_ce_fall("step period");  // step seen in slot 4
                    check_value("cpu_rdy", 16'(cpu_rdy), 16'h1);
                    @(posedge clk25);
                    step      <= 1'b0;
                    bp_enable <= 1'b0;
                end
                16'h6: begin                    // scroll register
                    @(posedge clk25);
                    roll <= dat[7:0];
                end
                16'h7: begin                    // pause switch
                    @(posedge clk25);
                    cpu_pause <= 1'b1;
                    @(negedge clk25);
                    check_value("cpu_rdy", 16'(cpu_rdy), 16'h0);
                    @(posedge clk25);
                    cpu_pause <= 1'b0;
                    @(negedge clk25);
                    check_value("cpu_rdy", 16'(cpu_rdy), 16'h1);
                end
                default: begin
                    errors++;
                    $display("unknown operation %h in the pattern file", op);
                end
            endcase
        end

        repeat (3 * H_TOTAL) @(negedge clk25);  // a few lines of video only
        assert (vid_loads > 0) else begin
            errors++;
            $display("no video load was seen during the run");
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule : tb_bk_memory

`default_nettype wire

// File: testbench/bk_memory_patterns.txt
// columns: op addr data expect, hex; op 0 cpu read, 1 cpu write, 2 byte write, 3 host write,
// 4 host read, 5 breakpoint fetch, 6 roll, 7 pause, ffff ends; cpu byte addr, host word addr
0 0100 0000 a543  // fill of word 0080
1 0100 1234 1234
0 0100 0000 1234
1 0102 beef beef  // word 0081
0 0102 0000 beef
2 0101 ab00 ab34  // upper lane of 0080
2 0102 00cd becd  // lower lane of 0081
0 0100 0000 ab34
0 0102 0000 becd
3 1000 5a5a 5a5a  // host word 1000
4 1000 0000 5a5a
0 2000 0000 5a5a  // same word seen by the cpu
3 8000 0200 25c3  // breakpoint register, sram keeps its fill
4 8000 0000 0200
6 0000 0012 0000
5 0200 0000 a4c3  // fetch of word 0100 hits
7 0000 0000 0000
1 4000 c0de c0de  // first screen word 2000
4 2000 0000 c0de
6 0000 00a7 0000
ffff 0000 0000 0000

// File: sim.f
design/bk_mem_pkg.sv
design/cpu_bus_sequencer.sv
design/video_fetch.sv
design/sram_arbiter.sv
design/bk_memory_top.sv
testbench/tb_bk_memory.sv

// File: Bender.yml
package:
  name: bk_memory

sources:
  - design/bk_mem_pkg.sv
  - design/cpu_bus_sequencer.sv
  - design/video_fetch.sv
  - design/sram_arbiter.sv
  - design/bk_memory_top.sv
  - target: simulation
    files:
      - testbench/tb_bk_memory.sv
